//--- logic/ahbPkg.sv
package ahbPkg;

    ////////////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////////////
    localparam int addrWidth = 32;          // HADDR width
    localparam int dataWidth = 32;          // HWDATA / HRDATA width

    ////////////////////////////////////////////////////////////
    // transfer attributes
    ////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        idle   = 2'b00,                     // no transfer
        busy   = 2'b01,                     // burst pause, never issued here
        nonSeq = 2'b10,                     // single or first of burst
        seq    = 2'b11                      // rest of burst
    } transT;

    typedef enum logic [2:0] {
        sizeByte = 3'b000,                  // 8 bit
        sizeHalf = 3'b001,                  // 16 bit
        sizeWord = 3'b010                   // 32 bit, widest legal
    } sizeT;

    // which slave owns the data phase
    typedef enum logic [1:0] {
        selRam  = 2'b00,
        selGpio = 2'b01,
        selNone = 2'b10                     // unmapped or idle
    } slaveSelT;

    ////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////
    localparam int regionMsb = 31;          // top byte picks region
    localparam int regionLsb = 24;
    localparam logic [7:0] ramRegion  = 8'h20;  // 0x2000_0000
    localparam logic [7:0] gpioRegion = 8'h50;  // 0x5000_0000

    localparam logic [3:0] gpioOut0Off = 4'h0;  // rw
    localparam logic [3:0] gpioOut1Off = 4'h4;  // rw
    localparam logic [3:0] gpioIn0Off  = 4'h8;  // ro
    localparam logic [3:0] gpioIn1Off  = 4'hC;  // ro

    localparam logic [dataWidth-1:0] badData = 32'hDEAD_BEEF;  // unmapped read value

endpackage

//--- logic/ahbInterconnect.sv
`timescale 1ns/100ps

module ahbInterconnect (
    input  logic                           HCLK,          // bus clock
    input  logic                           rstN,          // async reset, active low
    // address phase from master
    input  logic [ahbPkg::addrWidth-1:0]   hAddr,
    input  ahbPkg::transT                  hTrans,
    // slave returns
    input  logic [ahbPkg::dataWidth-1:0]   ramRData,
    input  logic                           ramReadyOut,
    input  logic [ahbPkg::dataWidth-1:0]   gpioRData,
    input  logic                           gpioReadyOut,
    // selects out
    output logic                           ramSel,
    output logic                           gpioSel,
    // back to master and all slaves
    output logic [ahbPkg::dataWidth-1:0]   hRData,
    output logic                           hReady
);

    localparam int regionBits = ahbPkg::regionMsb - ahbPkg::regionLsb + 1;

    logic [regionBits-1:0] region;          // top address byte
    logic                  transActive;     // nonSeq or seq
    ahbPkg::slaveSelT      addrOwner;       // owner decoded this cycle
    ahbPkg::slaveSelT      dataOwner;       // owner of current data phase

    ////////////////////////////////////////////////////////////
    // address decode, zero cycles
    ////////////////////////////////////////////////////////////
    assign region      = hAddr[ahbPkg::regionMsb:ahbPkg::regionLsb];
    assign transActive = (hTrans == ahbPkg::nonSeq) || (hTrans == ahbPkg::seq);

    assign ramSel  = (region == ahbPkg::ramRegion);     // address only, slave checks hTrans
    assign gpioSel = (region == ahbPkg::gpioRegion);

    always_comb begin
        addrOwner = ahbPkg::selNone;                    // idle or unmapped
        if (transActive && ramSel) begin
            addrOwner = ahbPkg::selRam;
        end else if (transActive && gpioSel) begin
            addrOwner = ahbPkg::selGpio;
        end
    end

    ////////////////////////////////////////////////////////////
    // data phase owner
    ////////////////////////////////////////////////////////////
    always_ff @(posedge HCLK or negedge rstN) begin
        if (!rstN) begin
            dataOwner <= ahbPkg::selNone;               // ready high out of reset
        end else if (hReady) begin
            dataOwner <= addrOwner;                     // every completing edge
        end
    end

    // read data and ready mux
    always_comb begin
        case (dataOwner)
            ahbPkg::selRam: begin
                hRData = ramRData;
                hReady = ramReadyOut;                   // one wait state on reads
            end
            ahbPkg::selGpio: begin
                hRData = gpioRData;
                hReady = gpioReadyOut;
            end
            default: begin
                hRData = ahbPkg::badData;               // unmapped, no wait
                hReady = 1'b1;
            end
        endcase
    end

    // the address map must never overlap two slaves
    assert property (@(posedge HCLK) disable iff (!rstN)
        !(ramSel && gpioSel))
        else $error("ahbInterconnect: ramSel and gpioSel both high");

endmodule

//--- logic/ahbRam.sv
`timescale 1ns/100ps

module ahbRam #(
    parameter int ramAddrBits = 10                      // word address bits
) (
    input  logic                           HCLK,
    input  logic                           rstN,
    input  logic                           sel,         // from decoder
    input  logic                           hReady,      // combined ready
    input  logic [ahbPkg::addrWidth-1:0]   hAddr,
    input  ahbPkg::transT                  hTrans,
    input  logic                           hWrite,
    input  ahbPkg::sizeT                   hSize,
    input  logic [ahbPkg::dataWidth-1:0]   hWData,
    output logic [ahbPkg::dataWidth-1:0]   rData,
    output logic                           readyOut
);

    localparam int laneCount = ahbPkg::dataWidth / 8;  // byte lanes

    logic [ahbPkg::dataWidth-1:0] mem [2**ramAddrBits]; // block RAM array

    logic                   accept;         // address phase taken
    logic                   writePend;      // write data phase next
    logic                   readPend;       // read wait state
    logic [ramAddrBits-1:0] wordIdx;        // latched word index
    logic [1:0]             laneOff;        // latched byte offset
    ahbPkg::sizeT           sizeQ;          // latched size
    logic [laneCount-1:0]   byteEn;         // lanes to write

    assign accept = sel && hReady &&
                    ((hTrans == ahbPkg::nonSeq) || (hTrans == ahbPkg::seq));

    ////////////////////////////////////////////////////////////
    // address phase
    ////////////////////////////////////////////////////////////
    always_ff @(posedge HCLK or negedge rstN) begin
        if (!rstN) begin
            writePend <= 1'b0;
            readPend  <= 1'b0;
        end else begin
            writePend <= accept && hWrite;
            readPend  <= accept && !hWrite;             // cleared next edge, hReady low then
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            wordIdx <= hAddr[ramAddrBits+1:2];          // aliases inside region
            laneOff <= hAddr[1:0];
            sizeQ   <= hSize;
        end
    end

    // lane enables from size and offset
    always_comb begin
        case (sizeQ)
            ahbPkg::sizeByte: byteEn = laneCount'(1) << laneOff;
            ahbPkg::sizeHalf: byteEn = laneCount'(3) << {laneOff[1], 1'b0};
            default:          byteEn = '1;              // full word
        endcase
    end

    ////////////////////////////////////////////////////////////
    // array, write at end of data phase, registered read
    ////////////////////////////////////////////////////////////
    always_ff @(posedge HCLK) begin
        if (writePend && hReady) begin
            for (int i = 0; i < laneCount; i++) begin
                if (byteEn[i]) mem[wordIdx][8*i +: 8] <= hWData[8*i +: 8];
            end
        end
        if (readPend) rData <= mem[wordIdx];            // valid for second data cycle
    end

    assign readyOut = !readPend;

    assert property (@(posedge HCLK) disable iff (!rstN)
        accept |-> (hSize <= ahbPkg::sizeWord))
        else $error("ahbRam: transfer wider than a word");

    assert property (@(posedge HCLK) disable iff (!rstN)
        accept |-> !((hSize == ahbPkg::sizeHalf) && hAddr[0]) &&
                   !((hSize == ahbPkg::sizeWord) && (hAddr[1:0] != 2'b00)))
        else $error("ahbRam: unaligned access at %h", hAddr);

endmodule

//--- logic/ahbGpio.sv
`timescale 1ns/100ps

module ahbGpio #(
    parameter int gpioWidth = 16                        // bits per port
) (
    input  logic                           HCLK,
    input  logic                           rstN,
    input  logic                           sel,
    input  logic                           hReady,
    input  logic [ahbPkg::addrWidth-1:0]   hAddr,
    input  ahbPkg::transT                  hTrans,
    input  logic                           hWrite,
    input  ahbPkg::sizeT                   hSize,
    input  logic [ahbPkg::dataWidth-1:0]   hWData,
    input  logic [gpioWidth-1:0]           pinIn0,      // async pins
    input  logic [gpioWidth-1:0]           pinIn1,
    output logic [ahbPkg::dataWidth-1:0]   rData,
    output logic                           readyOut,
    output logic [gpioWidth-1:0]           pinOut0,     // offset 0
    output logic [gpioWidth-1:0]           pinOut1      // offset 4
);

    logic                 accept;           // address phase taken
    logic                 writePend;        // write data phase now
    logic [3:0]           offQ;             // latched register offset
    logic [gpioWidth-1:0] in0Meta;          // first sync stage
    logic [gpioWidth-1:0] in0Sync;
    logic [gpioWidth-1:0] in1Meta;
    logic [gpioWidth-1:0] in1Sync;

    assign accept = sel && hReady &&
                    ((hTrans == ahbPkg::nonSeq) || (hTrans == ahbPkg::seq));

    ////////////////////////////////////////////////////////////
    // input synchronizers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge HCLK or negedge rstN) begin
        if (!rstN) begin
            in0Meta <= '0;
            in0Sync <= '0;
            in1Meta <= '0;
            in1Sync <= '0;
        end else begin
            in0Meta <= pinIn0;
            in0Sync <= in0Meta;                         // two flops deep
            in1Meta <= pinIn1;
            in1Sync <= in1Meta;
        end
    end

    ////////////////////////////////////////////////////////////
    // bus side
    ////////////////////////////////////////////////////////////
    always_ff @(posedge HCLK) begin
        if (accept) offQ <= hAddr[3:0];                 // word offset in block
    end

    always_ff @(posedge HCLK or negedge rstN) begin
        if (!rstN) begin
            readyOut  <= 1'b0;
            writePend <= 1'b0;
            pinOut0   <= '0;
            pinOut1   <= '0;
        end else begin
            readyOut  <= 1'b1;                          // never stalls
            writePend <= accept && hWrite;
            if (writePend && hReady) begin
                case (offQ)
                    ahbPkg::gpioOut0Off: pinOut0 <= hWData[gpioWidth-1:0];
                    ahbPkg::gpioOut1Off: pinOut1 <= hWData[gpioWidth-1:0];
                    default: ;                          // input offsets read only
                endcase
            end
        end
    end

    // read mux, zero extended
    always_comb begin
        case (offQ)
            ahbPkg::gpioOut0Off: rData = ahbPkg::dataWidth'(pinOut0);
            ahbPkg::gpioOut1Off: rData = ahbPkg::dataWidth'(pinOut1);
            ahbPkg::gpioIn0Off:  rData = ahbPkg::dataWidth'(in0Sync);
            ahbPkg::gpioIn1Off:  rData = ahbPkg::dataWidth'(in1Sync);
            default:             rData = '0;
        endcase
    end

    assert property (@(posedge HCLK) disable iff (!rstN)
        accept |-> (hSize == ahbPkg::sizeWord))
        else $error("ahbGpio: non-word access at %h", hAddr);

endmodule

//--- logic/ahbLiteTop.sv
`timescale 1ns/100ps

module ahbLiteTop #(
    parameter int ramAddrBits = 10,                     // 4 KiB RAM
    parameter int gpioWidth   = 16
) (
    input  logic                           HCLK,        // bus clock
    input  logic                           rstN,        // bus reset, active low
    // master port
    input  logic [ahbPkg::addrWidth-1:0]   hAddr,
    input  ahbPkg::transT                  hTrans,
    input  logic                           hWrite,
    input  ahbPkg::sizeT                   hSize,
    input  logic [ahbPkg::dataWidth-1:0]   hWData,
    output logic [ahbPkg::dataWidth-1:0]   hRData,
    output logic                           hReady,
    // GPIO pins
    input  logic [gpioWidth-1:0]           gpioIn0,
    input  logic [gpioWidth-1:0]           gpioIn1,
    output logic [gpioWidth-1:0]           gpioOut0,
    output logic [gpioWidth-1:0]           gpioOut1
);

    logic                         ramSel;         // slave selects
    logic                         gpioSel;
    logic [ahbPkg::dataWidth-1:0] ramRData;       // slave read data
    logic [ahbPkg::dataWidth-1:0] gpioRData;
    logic                         ramReadyOut;    // slave ready
    logic                         gpioReadyOut;

    ////////////////////////////////////////////////////////////
    // decoder and read mux
    ////////////////////////////////////////////////////////////
    ahbInterconnect fabric (
        .HCLK         (HCLK),
        .rstN         (rstN),
        .hAddr        (hAddr),
        .hTrans       (hTrans),
        .ramRData     (ramRData),
        .ramReadyOut  (ramReadyOut),
        .gpioRData    (gpioRData),
        .gpioReadyOut (gpioReadyOut),
        .ramSel       (ramSel),
        .gpioSel      (gpioSel),
        .hRData       (hRData),           // to master
        .hReady       (hReady)            // to master and slaves
    );

    ////////////////////////////////////////////////////////////
    // slaves
    ////////////////////////////////////////////////////////////
    ahbRam #(.ramAddrBits(ramAddrBits)) ram (
        .HCLK     (HCLK),
        .rstN     (rstN),
        .sel      (ramSel),
        .hReady   (hReady),
        .hAddr    (hAddr),
        .hTrans   (hTrans),
        .hWrite   (hWrite),
        .hSize    (hSize),
        .hWData   (hWData),
        .rData    (ramRData),
        .readyOut (ramReadyOut)
    );

    ahbGpio #(.gpioWidth(gpioWidth)) gpio (
        .HCLK     (HCLK),
        .rstN     (rstN),
        .sel      (gpioSel),
        .hReady   (hReady),
        .hAddr    (hAddr),
        .hTrans   (hTrans),
        .hWrite   (hWrite),
        .hSize    (hSize),
        .hWData   (hWData),
        .pinIn0   (gpioIn0),              // read at offset 8
        .pinIn1   (gpioIn1),              // read at offset C
        .rData    (gpioRData),
        .readyOut (gpioReadyOut),
        .pinOut0  (gpioOut0),
        .pinOut1  (gpioOut1)
    );

endmodule

//--- dv/ahbLiteTb.sv
`timescale 1ns/100ps

module ahbLiteTb;

    localparam int          ramAddrBits = 10;               // 4 KiB RAM
    localparam int          gpioWidth   = 16;
    localparam int          maxCycles   = 2000;             // ~4x the length of all tests
    localparam logic [31:0] ramBase     = 32'h2000_0000;
    localparam logic [31:0] gpioBase    = 32'h5000_0000;
    localparam logic [31:0] pinMask     = (32'd1 << gpioWidth) - 1;

    logic                         HCLK;
    logic                         rstN;
    logic [ahbPkg::addrWidth-1:0] hAddr;
    ahbPkg::transT                hTrans;
    logic                         hWrite;
    ahbPkg::sizeT                 hSize;
    logic [ahbPkg::dataWidth-1:0] hWData;
    logic [ahbPkg::dataWidth-1:0] hRData;
    logic                         hReady;
    logic [gpioWidth-1:0]         gpioIn0;
    logic [gpioWidth-1:0]         gpioIn1;
    logic [gpioWidth-1:0]         gpioOut0;
    logic [gpioWidth-1:0]         gpioOut1;

    int                           errorCount = 0;
    int                           cycleCount = 0;
    integer                       seed;
    logic [31:0]                  expOut0;                  // last values written to outputs
    logic [31:0]                  expOut1;

    ahbLiteTop #(.ramAddrBits(ramAddrBits), .gpioWidth(gpioWidth)) dut (
        .HCLK(HCLK), .rstN(rstN), .hAddr(hAddr), .hTrans(hTrans), .hWrite(hWrite),
        .hSize(hSize), .hWData(hWData), .hRData(hRData), .hReady(hReady),
        .gpioIn0(gpioIn0), .gpioIn1(gpioIn1), .gpioOut0(gpioOut0), .gpioOut1(gpioOut1)
    );

    initial HCLK = 1'b0;
    always #50 HCLK = ~HCLK;                                // 100 ns period

    always @(posedge HCLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("run stopped after %0d cycles, the bus never finished", cycleCount);
            $display("*** FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // bus master
    ////////////////////////////////////////////////////////////
    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            errorCount++;
            $display("Error %s: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    task automatic busWrite(input logic [31:0] addr, input ahbPkg::sizeT size,
                            input logic [31:0] data);
        @(posedge HCLK);
        hAddr  <= addr;
        hTrans <= ahbPkg::nonSeq;
        hWrite <= 1'b1;
        hSize  <= size;
        do @(posedge HCLK); while (!hReady);                // address phase taken
        hTrans <= ahbPkg::idle;
        hWData <= data;                                     // data phase
        do @(posedge HCLK); while (!hReady);
    endtask

    task automatic busRead(input logic [31:0] addr, input ahbPkg::sizeT size,
                           output logic [31:0] data, output int waits);
        waits = 0;
        @(posedge HCLK);
        hAddr  <= addr;
        hTrans <= ahbPkg::nonSeq;
        hWrite <= 1'b0;
        hSize  <= size;
        do @(posedge HCLK); while (!hReady);
        hTrans <= ahbPkg::idle;
        do begin
            @(posedge HCLK);
            if (!hReady) waits++;                           // wait state seen
        end while (!hReady);
        data = hRData;                                      // value at the ending edge
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////
    task automatic resetState;
        @(negedge HCLK);
        checkValue("resetState hReady", 32'd1, hReady);
        checkValue("resetState gpioOut0", 32'd0, gpioOut0);
        checkValue("resetState gpioOut1", 32'd0, gpioOut1);
    endtask

    task automatic ramWords;
        logic [31:0] addrs [32];
        logic [31:0] datas [32];
        logic [31:0] expected;
        logic [31:0] got;
        int          waits;
        for (int i = 0; i < 32; i++) begin
            addrs[i] = ramBase | ($random(seed) & 32'h0000_0FFC); // word aligned in 4 KiB
            datas[i] = $random(seed);
            busWrite(addrs[i], ahbPkg::sizeWord, datas[i]);
        end
        // all writes land first, so a wrong word index shows up
        for (int i = 0; i < 32; i++) begin
            expected = datas[i];
            for (int j = i + 1; j < 32; j++) begin
                if (addrs[j] == addrs[i]) expected = datas[j];  // later write wins
            end
            busRead(addrs[i], ahbPkg::sizeWord, got, waits);
            checkValue("ramWords data", expected, got);
            checkValue("ramWords waits", 32'd1, waits);
        end
    endtask

    task automatic ramLanes;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] lanes;
        logic [31:0] mask;
        logic [31:0] got;
        int          waits;
        addr = ramBase + 32'h100;
        word = $random(seed);
        busWrite(addr, ahbPkg::sizeWord, word);
        for (int off = 0; off < 4; off++) begin
            lanes = $random(seed);                          // unused lanes carry noise
            mask  = 32'h0000_00FF << (8 * off);
            busWrite(addr + off, ahbPkg::sizeByte, lanes);
            word  = (word & ~mask) | (lanes & mask);
            busRead(addr, ahbPkg::sizeWord, got, waits);
            checkValue("ramLanes byte", word, got);
        end
        for (int off = 0; off < 4; off += 2) begin
            lanes = $random(seed);
            mask  = 32'h0000_FFFF << (8 * off);
            busWrite(addr + off, ahbPkg::sizeHalf, lanes);
            word  = (word & ~mask) | (lanes & mask);
            busRead(addr, ahbPkg::sizeWord, got, waits);
            checkValue("ramLanes half", word, got);
        end
    endtask

    task automatic gpioOutputs;
        logic [31:0] value0;
        logic [31:0] value1;
        logic [31:0] got;
        int          waits;
        value0 = $random(seed);
        value1 = $random(seed);
        busWrite(gpioBase | ahbPkg::gpioOut0Off, ahbPkg::sizeWord, value0);
        busWrite(gpioBase | ahbPkg::gpioOut1Off, ahbPkg::sizeWord, value1);
        expOut0 = value0 & pinMask;                         // truncated to port width
        expOut1 = value1 & pinMask;
        @(negedge HCLK);
        checkValue("gpioOutputs pin0", expOut0, gpioOut0);
        checkValue("gpioOutputs pin1", expOut1, gpioOut1);
        busRead(gpioBase | ahbPkg::gpioOut0Off, ahbPkg::sizeWord, got, waits);
        checkValue("gpioOutputs read0", expOut0, got);
        checkValue("gpioOutputs waits", 32'd0, waits);
        busRead(gpioBase | ahbPkg::gpioOut1Off, ahbPkg::sizeWord, got, waits);
        checkValue("gpioOutputs read1", expOut1, got);
    endtask

    task automatic gpioInputs;
        logic [gpioWidth-1:0] in0;
        logic [gpioWidth-1:0] in1;
        logic [31:0]          got;
        int                   waits;
        in0 = $random(seed);
        in1 = $random(seed);
        @(posedge HCLK);
        gpioIn0 <= in0;
        gpioIn1 <= in1;
        repeat (3) @(posedge HCLK);                         // through the synchronizer
        busRead(gpioBase | ahbPkg::gpioIn0Off, ahbPkg::sizeWord, got, waits);
        checkValue("gpioInputs in0", {16'h0000, in0}, got);
        busRead(gpioBase | ahbPkg::gpioIn1Off, ahbPkg::sizeWord, got, waits);
        checkValue("gpioInputs in1", {16'h0000, in1}, got);
        // writes to the input offsets must be dropped
        busWrite(gpioBase | ahbPkg::gpioIn0Off, ahbPkg::sizeWord, ~{16'h0000, in0});
        busWrite(gpioBase | ahbPkg::gpioIn1Off, ahbPkg::sizeWord, ~{16'h0000, in1});
        busRead(gpioBase | ahbPkg::gpioIn0Off, ahbPkg::sizeWord, got, waits);
        checkValue("gpioInputs in0 after write", {16'h0000, in0}, got);
        busRead(gpioBase | ahbPkg::gpioIn1Off, ahbPkg::sizeWord, got, waits);
        checkValue("gpioInputs in1 after write", {16'h0000, in1}, got);
        @(negedge HCLK);
        checkValue("gpioInputs pin0 kept", expOut0, gpioOut0);
        checkValue("gpioInputs pin1 kept", expOut1, gpioOut1);
    endtask

    task automatic unmappedReads;
        logic [31:0] word;
        logic [31:0] got;
        int          waits;
        word = $random(seed);
        busWrite(ramBase + 32'h200, ahbPkg::sizeWord, word);
        busRead(32'h0000_0000, ahbPkg::sizeWord, got, waits);
        checkValue("unmappedReads 0x0", 32'hDEAD_BEEF, got);
        checkValue("unmappedReads 0x0 waits", 32'd0, waits);
        busRead(32'h4000_0000, ahbPkg::sizeWord, got, waits);
        checkValue("unmappedReads 0x4", 32'hDEAD_BEEF, got);
        checkValue("unmappedReads 0x4 waits", 32'd0, waits);
        busRead(ramBase + 32'h200, ahbPkg::sizeWord, got, waits);
        checkValue("unmappedReads ram", word, got);
        checkValue("unmappedReads ram waits", 32'd1, waits);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        seed    = 32'he080_a2a0;
        expOut0 = '0;
        expOut1 = '0;
        rstN    = 1'b0;
        hAddr   = '0;
        hTrans  = ahbPkg::idle;
        hWrite  = 1'b0;
        hSize   = ahbPkg::sizeWord;
        hWData  = '0;
        gpioIn0 = '0;
        gpioIn1 = '0;
        repeat (2) @(posedge HCLK);                         // two reset cycles
        rstN <= 1'b1;
        resetState();
        ramWords();
        ramLanes();
        gpioOutputs();
        gpioInputs();
        unmappedReads();
        repeat (2) @(posedge HCLK);
        $display("tests done, %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- sim.f
logic/ahbPkg.sv
logic/ahbInterconnect.sv
logic/ahbRam.sv
logic/ahbGpio.sv
logic/ahbLiteTop.sv
dv/ahbLiteTb.sv
